/* hw/sccbPkg.sv */
`default_nettype none

package sccbPkg;

	// Write address of the sensor on the two-wire bus
	localparam logic [7:0] sccbWriteId = 8'h78;

	// Eight data bits plus the don't-care ninth bit
	localparam int sccbBitsPerPhase = 9;

	// ID, sub-address, data
	localparam int sccbPhases = 3;

	// Sub-address phase carries two bytes on this sensor
	localparam int sccbFrameBits = sccbBitsPerPhase * (sccbPhases + 1);

endpackage

`default_nettype wire

/* hw/cameraCfgPkg.sv */
`default_nettype none

package cameraCfgPkg;

	// One table word is {regAddr, regData}
	localparam int cfgEntryWidth = 24;
	localparam int regAddrWidth  = 16;
	localparam int regDataWidth  = 8;

	// Table geometry
	localparam int cfgIndexWidth = 5;
	localparam int cfgTableSize  = 32;

	// Entry writing 0x3008 = 0x82, needs settling time afterwards
	localparam int cfgSoftResetIndex = 1;

endpackage

`default_nettype wire

/* hw/ov5640RegTable.sv */
`timescale 1ns/1ps
`default_nettype none

module ov5640RegTable
	import cameraCfgPkg::*;
(
	input  logic [cfgIndexWidth-1:0] index,
	output logic [cfgEntryWidth-1:0] entry,
	output logic [cfgIndexWidth:0]   tableSize
);

	assign tableSize = (cfgIndexWidth + 1)'(cfgTableSize); // Fixed length

	always_comb
	begin
		case (index)
			5'd0:    entry = 24'h310311; // System clock from pad
			5'd1:    entry = 24'h300882; // Software reset
			5'd2:    entry = 24'h300842; // Software power down
			5'd3:    entry = 24'h310303; // System clock from PLL
			5'd4:    entry = 24'h3017ff; // VSYNC, HREF, PCLK, D[9:6] enable
			5'd5:    entry = 24'h3018ff; // D[5:0] enable
			5'd6:    entry = 24'h303713; // PLL root and pre-divider
			5'd7:    entry = 24'h310801; // PCLK and SCLK root dividers
			5'd8:    entry = 24'h303541; // PLL, PCLK near 84 MHz
			5'd9:    entry = 24'h303669; // PLL multiplier
			5'd10:   entry = 24'h300000; // Enable blocks
			5'd11:   entry = 24'h3004ff; // Enable clocks
			5'd12:   entry = 24'h300e58; // MIPI down, DVP on
			5'd13:   entry = 24'h430061; // RGB565 output format
			5'd14:   entry = 24'h501f01; // ISP in RGB mode
			5'd15:   entry = 24'h380000; // HS high
			5'd16:   entry = 24'h380100; // HS low
			5'd17:   entry = 24'h380200; // VS high
			5'd18:   entry = 24'h3803fa; // VS low
			5'd19:   entry = 24'h38040a; // HW high
			5'd20:   entry = 24'h38053f; // HW low
			5'd21:   entry = 24'h380606; // VH high
			5'd22:   entry = 24'h3807a9; // VH low
			5'd23:   entry = 24'h380805; // Output width 1280
			5'd24:   entry = 24'h380900;
			5'd25:   entry = 24'h380a02; // Output height 720
			5'd26:   entry = 24'h380bd0;
			5'd27:   entry = 24'h380c07; // HTS
			5'd28:   entry = 24'h380d64;
			5'd29:   entry = 24'h380e02; // VTS
			5'd30:   entry = 24'h380fe4;
			5'd31:   entry = 24'h300802; // Wake up from standby
			default: entry = '0;         // Out of range
		endcase
	end

endmodule

`default_nettype wire

/* hw/resetDelayTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module resetDelayTimer #(
	parameter int resetDelay = 250000 // Settling cycles after soft reset
) (
	input  logic clk,
	input  logic arstN,
	input  logic delayStart,
	output logic delayBusy
);

	localparam int cntWidth = $clog2(resetDelay + 1);

	logic [cntWidth-1:0] count; // Remaining settle cycles

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			count <= '0;
		else if (delayStart)
			count <= cntWidth'(resetDelay); // Load, busy from next cycle
		else if (count != '0)
			count <= count - 1'b1;
	end

	assign delayBusy = (count != '0); // High for exactly resetDelay cycles

endmodule

`default_nettype wire

/* hw/cfgSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module cfgSequencer
	import cameraCfgPkg::*;
(
	input  logic                     clk,
	input  logic                     arstN,
	input  logic                     reconfig,
	input  logic [cfgEntryWidth-1:0] entry,
	input  logic [cfgIndexWidth:0]   tableSize,
	output logic [cfgIndexWidth-1:0] index,
	output logic                     wrStart,
	output logic [regAddrWidth-1:0]  wrAddr,
	output logic [regDataWidth-1:0]  wrData,
	input  logic                     wrDone,
	output logic                     delayStart,
	input  logic                     delayBusy,
	output logic                     cfgDone
);

	typedef enum logic [2:0] {idle, issue, waitWrite, settle, done} seqState_t;

	seqState_t state;
	logic      lastEntry;      // Current entry is the final one
	logic      softResetEntry; // Current entry needs the settle delay

	assign lastEntry      = (({1'b0, index} + 1'b1) == tableSize);
	assign softResetEntry = (index == cfgIndexWidth'(cfgSoftResetIndex));

	// Entry split straight from the table
	assign wrAddr = entry[cfgEntryWidth-1 -: regAddrWidth];
	assign wrData = entry[regDataWidth-1:0];

	// Settle exits straight into a write so the gap is resetDelay + 1
	assign wrStart    = (state == issue) || ((state == settle) && !delayBusy);
	assign delayStart = (state == waitWrite) && wrDone && softResetEntry;
	assign cfgDone    = (state == done);

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= idle; // Reset itself requests a full pass
			index <= '0;
		end
		else
		begin
			case (state)
				idle:
					state <= issue;
				issue:
					state <= waitWrite; // Strobe lasts one cycle
				waitWrite:
					if (wrDone)
					begin
						if (lastEntry)
							state <= done; // Index parks on the last entry
						else
						begin
							index <= index + 1'b1;
							state <= softResetEntry ? settle : issue;
						end
					end
				settle:
					if (!delayBusy)
						state <= waitWrite; // Write already strobed this cycle
				done:
					if (reconfig) // Only honored once finished
					begin
						index <= '0;
						state <= issue;
					end
				default:
					state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/sccbWriter.sv */
`timescale 1ns/1ps
`default_nettype none

module sccbWriter
	import sccbPkg::*;
	import cameraCfgPkg::*;
#(
	parameter int sclDiv = 125 // Clock cycles per quarter SCL period
) (
	input  logic                    clk,
	input  logic                    arstN,
	input  logic                    wrStart,
	input  logic [regAddrWidth-1:0] wrAddr,
	input  logic [regDataWidth-1:0] wrData,
	output logic                    wrDone,
	output logic                    scl,
	output logic                    sdaOut
);

	localparam int divWidth    = $clog2(sclDiv + 1);
	localparam int bitQuarters = sccbFrameBits * 4;  // Four quarters per bit
	localparam int lastQuarter = bitQuarters + 3;    // Plus two start, two stop

	logic                     busy;
	logic [divWidth-1:0]      divCnt;   // Cycles within a quarter
	logic [7:0]               qCnt;     // Quarter index within the write
	logic [7:0]               nextQ;
	logic [7:0]               bitQ;     // Quarter offset inside the data bits
	logic                     quarterTick;
	logic [sccbFrameBits-1:0] frame;    // MSB first, released bit after each byte

	assign nextQ       = qCnt + 1'b1;
	assign bitQ        = nextQ - 8'd2;
	assign quarterTick = busy && (divCnt == divWidth'(sclDiv - 1));

	// Payload only, loaded on every accepted strobe
	always_ff @(posedge clk)
	begin
		if (wrStart && !busy)
			frame <= {sccbWriteId, 1'b1, wrAddr[15:8], 1'b1, wrAddr[7:0], 1'b1,
				wrData, 1'b1};
		else if (quarterTick && (nextQ >= 8'd2) && (nextQ < 8'(bitQuarters + 2))
			&& (bitQ[1:0] == 2'd0))
			frame <= frame << 1; // Next bit to the top
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			busy   <= 1'b0;
			divCnt <= '0;
			qCnt   <= '0;
			scl    <= 1'b1; // Bus idles released
			sdaOut <= 1'b1;
			wrDone <= 1'b0;
		end
		else
		begin
			wrDone <= 1'b0;
			if (!busy)
			begin
				if (wrStart)
				begin
					busy   <= 1'b1;
					divCnt <= '0;
					qCnt   <= '0;
					sdaOut <= 1'b0; // Start, SDA falls with SCL high
				end
			end
			else if (!quarterTick)
				divCnt <= divCnt + 1'b1;
			else
			begin
				divCnt <= '0;
				if (qCnt == 8'(lastQuarter))
				begin
					busy   <= 1'b0;
					sdaOut <= 1'b1; // Stop, SDA rises with SCL high
					wrDone <= 1'b1;
				end
				else
				begin
					qCnt <= nextQ;
					if (nextQ == 8'd1)
						scl <= 1'b0;
					else if (nextQ < 8'(bitQuarters + 2))
					begin
						case (bitQ[1:0])
							2'd0:    sdaOut <= frame[sccbFrameBits-1]; // SCL low
							2'd1:    scl <= 1'b1;
							2'd3:    scl <= 1'b0;
							default: scl <= 1'b1; // Hold high mid-bit
						endcase
					end
					else if (nextQ == 8'(bitQuarters + 2))
						sdaOut <= 1'b0; // Pull low ahead of stop
					else
						scl <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hw/cameraCfgTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cameraCfgTop
	import cameraCfgPkg::*;
#(
	parameter int sclDiv     = 125,   // Quarter SCL period in clocks
	parameter int resetDelay = 250000 // Soft reset settling in clocks
) (
	input  logic clk,
	input  logic arstN,
	input  logic reconfig,
	output logic scl,
	output logic sdaOut, // 1 releases the line
	output logic cfgDone
);

	logic [cfgIndexWidth-1:0] index;
	logic [cfgEntryWidth-1:0] entry;
	logic [cfgIndexWidth:0]   tableSize;
	logic                     delayStart;
	logic                     delayBusy;
	logic                     wrStart;
	logic                     wrDone;
	logic [regAddrWidth-1:0]  wrAddr;
	logic [regDataWidth-1:0]  wrData;

	ov5640RegTable i_regTable (
		.index     (index),
		.entry     (entry),
		.tableSize (tableSize)
	);

	resetDelayTimer #(.resetDelay(resetDelay)) i_delayTimer (
		.clk        (clk),
		.arstN      (arstN),
		.delayStart (delayStart),
		.delayBusy  (delayBusy)
	);

	cfgSequencer i_sequencer (
		.clk        (clk),
		.arstN      (arstN),
		.reconfig   (reconfig),
		.entry      (entry),
		.tableSize  (tableSize),
		.index      (index),
		.wrStart    (wrStart),
		.wrAddr     (wrAddr),
		.wrData     (wrData),
		.wrDone     (wrDone),
		.delayStart (delayStart),
		.delayBusy  (delayBusy),
		.cfgDone    (cfgDone)
	);

	sccbWriter #(.sclDiv(sclDiv)) i_writer (
		.clk     (clk),
		.arstN   (arstN),
		.wrStart (wrStart),
		.wrAddr  (wrAddr),
		.wrData  (wrData),
		.wrDone  (wrDone),
		.scl     (scl),
		.sdaOut  (sdaOut)
	);

endmodule

`default_nettype wire

/* sim/tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int periodNs    = 40,
	parameter int resetCycles = 2
) (
	output logic clk,
	output logic arstN
);

	initial
	begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;
	end

	initial
	begin
		arstN = 1'b0; // Held for the first cycles
		repeat (resetCycles) @(posedge clk);
		#2 arstN = 1'b1;
	end

endmodule

`default_nettype wire

/* sim/sccbMonitor.sv */
`timescale 1ns/1ps
`default_nettype none

module sccbMonitor
	import sccbPkg::*;
	import cameraCfgPkg::*;
#(
	parameter int resetDelay = 300 // Minimum quiet cycles after soft reset
) (
	input  logic clk,
	input  logic arstN,
	input  logic reconfig,
	input  logic scl,
	input  logic sdaOut,
	input  logic cfgDone,
	output int   testCount,
	output int   failCount,
	output int   errorCount
);

	localparam int frameBits = 4 * sccbBitsPerPhase; // ID, two address bytes, data

	// Bring-up words in table order, {regAddr, regData}
	localparam logic [cfgEntryWidth-1:0] refTable [0:cfgTableSize-1] = '{
		24'h310311, 24'h300882, 24'h300842, 24'h310303,
		24'h3017ff, 24'h3018ff, 24'h303713, 24'h310801,
		24'h303541, 24'h303669, 24'h300000, 24'h3004ff,
		24'h300e58, 24'h430061, 24'h501f01, 24'h380000,
		24'h380100, 24'h380200, 24'h3803fa, 24'h38040a,
		24'h38053f, 24'h380606, 24'h3807a9, 24'h380805,
		24'h380900, 24'h380a02, 24'h380bd0, 24'h380c07,
		24'h380d64, 24'h380e02, 24'h380fe4, 24'h300802
	};

	logic                 prevScl;
	logic                 prevSda;
	logic                 prevDone;
	logic                 bitPending;    // SCL went high inside a frame
	logic                 pendingBit;
	logic                 inFrame;
	logic                 resetChecked;
	logic                 awaitReconfig; // Bus must stay quiet
	logic                 afterSoftReset;
	logic [frameBits-1:0] shiftReg;
	int                   bitCount;
	int                   txCount;
	int                   passNum;
	int                   cycle;
	int                   stopCycle;
	int                   testErrors;

	function automatic logic [cfgEntryWidth-1:0] expectedEntry(input int idx);
		if (idx < 0 || idx >= cfgTableSize)
			return '0; // Nothing past the end
		return refTable[idx[cfgIndexWidth-1:0]];
	endfunction

	task automatic reportFail(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		errorCount++;
		testErrors++;
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (testErrors == 0)
			$display("Test %0d (%s): passed", testCount, name);
		else
		begin
			failCount++;
			$display("Test %0d (%s): failed with %0d errors", testCount, name, testErrors);
		end
		testErrors = 0;
	endtask

	task automatic checkFrame;
		logic [cfgEntryWidth-1:0] expWord;
		logic [cfgEntryWidth-1:0] gotWord;
		expWord = expectedEntry(txCount);
		gotWord = {shiftReg[26:19], shiftReg[17:10], shiftReg[8:1]}; // Skip don't-care bits
		if (bitCount != frameBits)
			reportFail($sformatf("write %0d has %0d bits, expected %0d", txCount, bitCount,
				frameBits));
		else if (shiftReg[35:28] != sccbWriteId)
			reportFail($sformatf("write %0d id 0x%02h, expected 0x%02h", txCount,
				shiftReg[35:28], sccbWriteId));
		else if (gotWord != expWord)
			reportFail($sformatf("write %0d got 0x%06h, expected 0x%06h", txCount, gotWord,
				expWord));
		afterSoftReset = (txCount == cfgSoftResetIndex);
		txCount++;
	endtask

	// Outputs are registered, so the falling clock edge sees them settled
	always @(negedge clk)
	begin
		if (!arstN)
		begin
			{prevScl, prevSda, prevDone} = 3'b110;
			{bitPending, pendingBit, inFrame, resetChecked} = 4'b0000;
			{awaitReconfig, afterSoftReset} = 2'b00;
			shiftReg = '0;
			{bitCount, txCount, passNum, cycle, stopCycle} = {5{32'sd0}};
			{testCount, failCount, errorCount, testErrors} = {4{32'sd0}};
		end
		else
		begin
			cycle++;
			if (!resetChecked)
			begin
				resetChecked = 1'b1;
				if (scl !== 1'b1 || sdaOut !== 1'b1 || cfgDone !== 1'b0)
					reportFail("bus not idle or cfgDone set after reset");
				finishTest("reset state");
			end
			if (reconfig)
				awaitReconfig = 1'b0;
			if (scl && prevScl && prevSda && !sdaOut) // Start
			begin
				if (inFrame)
					reportFail("start inside a write");
				if (awaitReconfig)
					reportFail("start after cfgDone without reconfig");
				if (afterSoftReset && (cycle - stopCycle) < resetDelay)
					reportFail($sformatf("soft reset gap %0d cycles", cycle - stopCycle));
				{inFrame, bitPending, afterSoftReset} = 3'b100;
				bitCount = 0;
			end
			else if (scl && prevScl && !prevSda && sdaOut) // Stop
			begin
				if (inFrame)
					checkFrame();
				else
					reportFail("stop without start");
				{inFrame, bitPending} = 2'b00;
				stopCycle = cycle;
			end
			else if (scl && !prevScl)
			begin
				bitPending = inFrame;
				pendingBit = sdaOut; // Committed on the falling edge
			end
			else if (!scl && prevScl && bitPending)
			begin
				shiftReg   = {shiftReg[frameBits-2:0], pendingBit};
				bitPending = 1'b0;
				bitCount++;
			end
			if (cfgDone && !prevDone)
			begin
				passNum++;
				if (inFrame)
					reportFail("cfgDone rose inside a write");
				if (txCount != cfgTableSize)
					reportFail($sformatf("%0d writes, expected %0d", txCount, cfgTableSize));
				finishTest($sformatf("configuration pass %0d", passNum));
				txCount = 0;
				awaitReconfig = 1'b1;
			end
			{prevScl, prevSda, prevDone} = {scl, sdaOut, cfgDone};
		end
	end

endmodule

`default_nettype wire

/* sim/cameraCfgTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cameraCfgTb;

	localparam int sclDiv        = 4;
	localparam int resetDelay    = 300;
	localparam int writeCycles   = 148 * sclDiv;                      // 37 SCL periods per write
	localparam int cycleLimit    = 2 * (32 * writeCycles + resetDelay) + 2000; // Two passes
	localparam int testsExpected = 3;                                  // Reset check and two passes
	localparam int quietCycles   = 200;

	logic clk;
	logic arstN;
	logic reconfig;
	logic scl;
	logic sdaOut;
	logic cfgDone;
	int   testCount;
	int   failCount;
	int   errorCount;
	int   cycleCount;
	int   seed;
	int   gap;

	tbClock #(.periodNs(40), .resetCycles(2)) i_clock (
		.clk   (clk),
		.arstN (arstN)
	);

	cameraCfgTop #(.sclDiv(sclDiv), .resetDelay(resetDelay)) i_dut (
		.clk      (clk),
		.arstN    (arstN),
		.reconfig (reconfig),
		.scl      (scl),
		.sdaOut   (sdaOut),
		.cfgDone  (cfgDone)
	);

	sccbMonitor #(.resetDelay(resetDelay)) i_monitor (
		.clk        (clk),
		.arstN      (arstN),
		.reconfig   (reconfig),
		.scl        (scl),
		.sdaOut     (sdaOut),
		.cfgDone    (cfgDone),
		.testCount  (testCount),
		.failCount  (failCount),
		.errorCount (errorCount)
	);

	task automatic waitConfigured;
		do
		begin
			@(posedge clk);
			#2;
		end
		while (!cfgDone);
	endtask

	initial
	begin
		reconfig = 1'b0;
		seed     = 32'h4e44;
		waitConfigured();
		gap = 10 + ($random(seed) & 255); // Idle before the second pass
		repeat (gap) @(posedge clk);
		#2 reconfig = 1'b1;
		@(posedge clk);
		#2 reconfig = 1'b0;
		waitConfigured();
		repeat (quietCycles) @(posedge clk); // Bus must stay idle here
		#2;
		$display("Tests run %0d, failed %0d, errors %0d", testCount, failCount, errorCount);
		if (errorCount == 0 && failCount == 0 && testCount == testsExpected)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial
	begin
		cycleCount = 0;
		while (cycleCount < cycleLimit)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: configuration never completed");
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
hw/sccbPkg.sv
hw/cameraCfgPkg.sv
hw/ov5640RegTable.sv
hw/resetDelayTimer.sv
hw/cfgSequencer.sv
hw/sccbWriter.sv
hw/cameraCfgTop.sv
sim/tbClock.sv
sim/sccbMonitor.sv
sim/cameraCfgTb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --top-module cameraCfgTb -f project.f > build.log 2>&1 \
	&& ./obj_dir/VcameraCfgTb > sim.log 2>&1 \
	|| { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "^Finished with no errors$" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }
